// File: files.f
hdl/mapper_pkg.sv
hdl/bank_if.sv
hdl/cart_control.sv
hdl/prg_map.sv
hdl/chr_map.sv
hdl/scanline_irq.sv
hdl/cool_mapper.sv
sim/tb_cool_mapper.sv

// File: Makefile
TOP = tb_cool_mapper

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: sim/tb_cool_mapper.sv
`timescale 1ns/10ps

module tb_cool_mapper;
	localparam int cycle_limit = 4000; // Generous margin over the directed tests

	logic m2;
	logic ppu_addr_in;
	logic romsel;
	logic cpu_rw_in;
	logic [14:0] cpu_addr_in;
	logic [7:0] cpu_data_in;
	logic ppu_rd_in;
	logic ppu_wr_in;
	logic [13:0] ppu_a;
	logic [26:13] cpu_addr_out;
	logic flash_we, flash_oe, sram_ce, sram_we, sram_oe;
	logic [7:0] ppu_addr_out;
	logic ppu_rd_out, ppu_wr_out, ppu_ciram_a10, irq;

	logic flash_we_seen;       // Sampled inside the write cycle
	logic sram_we_seen;
	logic [7:0] chr_bank [8];  // Expected 1 KB banks a-h
	logic [5:0] prg_bank [4];  // Expected 8 KB banks a-d
	logic [31:0] rnd;
	int cycles = 0;

	cool_mapper #(
		.use_mmc3(1'b1),
		.a12_low_cycles(3)
	) u_cool_mapper (.*);

	always #10 m2 = ~m2;

	always @(posedge m2)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic step();
		@(posedge m2);
		#2;
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Expected A26-A13 for an 8 KB bank
	function automatic logic [13:0] prg_addr(input logic [12:0] base, input logic [4:0] mask,
		input logic [5:0] bank);
		return {base | {8'd0, bank[5:1] & ~mask}, bank[0]};
	endfunction

	function automatic logic [7:0] chr_addr(input logic [7:0] bank, input logic [4:0] mask);
		return {bank[7:3] & ~mask, bank[2:0]};
	endfunction

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		step();
		romsel = ~addr[15];
		cpu_addr_in = addr[14:0];
		cpu_data_in = data;
		cpu_rw_in = 1'b0;
		#6;
		flash_we_seen = flash_we;
		sram_we_seen = sram_we;
		step();
		cpu_rw_in = 1'b1;
	endtask

	// Read-modify-write style with rw low across two edges
	task automatic cpu_write_twice(input logic [15:0] addr, input logic [7:0] first,
		input logic [7:0] second);
		step();
		romsel = ~addr[15];
		cpu_addr_in = addr[14:0];
		cpu_data_in = first;
		cpu_rw_in = 1'b0;
		step();
		cpu_data_in = second;
		step();
		cpu_rw_in = 1'b1;
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		step();
		romsel = ~addr[15];
		cpu_addr_in = addr[14:0];
		cpu_rw_in = 1'b1;
		#6; // m2 still high here
	endtask

	task automatic ppu_access(input logic [13:0] addr, input logic rd, input logic wr);
		step();
		ppu_a = addr;
		ppu_rd_in = rd;
		ppu_wr_in = wr;
		#6;
	endtask

	task automatic a12_pulse(input int low, input int high);
		step();
		ppu_a = 14'h0000;
		repeat (low) step();
		ppu_a = 14'h1000;
		repeat (high) step();
	endtask

	task automatic wait_irq(input logic level, input string what);
		int n;
		n = 0;
		while (irq !== level && n < 8)
		begin
			step();
			n++;
		end
		if (irq !== level)
		begin
			$display("irq did not %s within 8 cycles", what);
			$display("SOME TESTS FAILED");
			$fatal(1, "irq timeout");
		end
	endtask

	task automatic prg_window_sweep(input logic swap);
		int idx;
		for (int w = 0; w < 4; w++)
		begin
			cpu_read({1'b1, 2'(w), 13'h0000});
			idx = w;
			if (swap && w == 0)
				idx = 2;
			else if (swap && w == 2)
				idx = 0;
			check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(13'd0, 5'd0, prg_bank[idx])));
		end
	endtask

	task automatic chr_window_sweep(input logic swap);
		int idx;
		for (int w = 0; w < 8; w++)
		begin
			ppu_access({1'b0, 3'(w), 10'h2A5}, 1'b1, 1'b1);
			idx = ((w >= 4) != swap) ? 4 + w % 4 : w % 4; // 1 KB half or 2 KB pairs
			check("ppu_addr_out", 32'(ppu_addr_out), 32'(chr_addr(chr_bank[idx], 5'd0)));
		end
	endtask

	task automatic ciram_sweep(input logic [1:0] mode);
		logic [13:0] addr;
		logic expected;
		for (int i = 0; i < 4; i++)
		begin
			addr = {2'b10, 2'(i), 10'h3C5};
			ppu_access(addr, 1'b1, 1'b1);
			case (mode)
				2'b00: expected = addr[10]; // Vertical
				2'b01: expected = addr[11]; // Horizontal
				2'b10: expected = 1'b0;
				default: expected = 1'b1;
			endcase
			check("ppu_ciram_a10", 32'(ppu_ciram_a10), 32'(expected));
		end
	endtask

	task automatic reset_defaults();
		check("irq", 32'(irq), 1);
		cpu_read(16'h6000);
		check("sram_ce", 32'(sram_ce), 1); // SRAM disabled
		cpu_write(16'h8000, 8'h00);
		check("flash_we", 32'(flash_we_seen), 1);
		cpu_read(16'hC000);
		check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(13'd0, 5'd0, 6'd62)));
	endtask

	task automatic config_and_sram();
		logic [12:0] base;
		base = {5'd3, 8'h40};
		cpu_write(16'h5000, {3'b110, base[12:8]}); // 32 KB mode
		cpu_write(16'h5001, base[7:0]);
		cpu_write(16'h5002, 8'h03);
		cpu_write(16'h5005, {1'b0, 5'b10110, 2'b10}); // Bank a 44 and SRAM page 2
		cpu_read(16'h8000);
		check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(base, 5'h03, 6'b101100)));
		cpu_read(16'hE000);
		check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(base, 5'h03, 6'b101111)));
		cpu_write(16'h5007, 8'h01);
		cpu_read(16'h6000);
		check("sram_ce", 32'(sram_ce), 0);
		check("sram_oe", 32'(sram_oe), 0);
		check("sram_we", 32'(sram_we), 1);
		check("flash_oe", 32'(flash_oe), 1);
		check("cpu_addr_out[14:13]", 32'(cpu_addr_out[14:13]), 2);
		cpu_write(16'h6000, 8'h5A);
		check("sram_we", 32'(sram_we_seen), 0);
		cpu_write(16'h8000, 8'h00);
		check("flash_we", 32'(flash_we_seen), 1);
		cpu_write(16'h5007, 8'h05); // Flash writes allowed
		cpu_write(16'h8000, 8'h00);
		check("flash_we", 32'(flash_we_seen), 0);
	endtask

	task automatic uxrom_banking();
		logic [4:0] v;
		cpu_write(16'h5000, 8'h00);
		cpu_write(16'h5001, 8'h00);
		cpu_write(16'h5002, 8'h00);
		cpu_write(16'h5006, 8'h01);
		rnd = $urandom;
		v = rnd[4:0];
		cpu_write(16'h8000, {3'b000, v});
		cpu_read(16'h8000);
		check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(13'd0, 5'd0, {v, 1'b0})));
		cpu_read(16'hA000);
		check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(13'd0, 5'd0, {v, 1'b1})));
		cpu_read(16'hC000);
		check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(13'd0, 5'd0, 6'd62)));
		cpu_read(16'hE000);
		check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(13'd0, 5'd0, 6'd63)));
		cpu_write_twice(16'h8000, {3'b000, ~v}, {3'b000, v});
		cpu_read(16'h8000);
		check("cpu_addr_out", 32'(cpu_addr_out), 32'(prg_addr(13'd0, 5'd0, {~v, 1'b0})));
	endtask

	task automatic cnrom_chr();
		logic [4:0] c;
		logic [4:0] mask;
		rnd = $urandom;
		c = rnd[4:0];
		mask = rnd[12:8];
		cpu_write(16'h5004, {3'b000, mask});
		cpu_write(16'h5006, 8'h02);
		cpu_write(16'h8000, {3'b000, c});
		for (int i = 0; i < 8; i++)
		begin
			ppu_access({1'b0, 3'(i), 10'h155}, 1'b1, 1'b1);
			check("ppu_addr_out", 32'(ppu_addr_out), 32'(chr_addr({c, 3'(i)}, mask)));
		end
		ppu_access(14'h0400, 1'b0, 1'b0);
		check("ppu_rd_out", 32'(ppu_rd_out), 0);
		check("ppu_wr_out", 32'(ppu_wr_out), 1); // CHR writes still off
		ppu_access(14'h2400, 1'b0, 1'b0);
		check("ppu_rd_out", 32'(ppu_rd_out), 1);
		check("ppu_wr_out", 32'(ppu_wr_out), 1);
		cpu_write(16'h5007, 8'h07);
		ppu_access(14'h0400, 1'b0, 1'b0);
		check("ppu_rd_out", 32'(ppu_rd_out), 0);
		check("ppu_wr_out", 32'(ppu_wr_out), 0);
		ppu_access(14'h0400, 1'b1, 1'b1);
		check("ppu_rd_out", 32'(ppu_rd_out), 1);
		check("ppu_wr_out", 32'(ppu_wr_out), 1);
		ppu_access(14'h2400, 1'b0, 1'b0);
		check("ppu_rd_out", 32'(ppu_rd_out), 1);
		check("ppu_wr_out", 32'(ppu_wr_out), 1);
		cpu_write(16'h5004, 8'h00);
	endtask

	task automatic mirroring_modes();
		cpu_write(16'h5006, 8'h08); // AxROM
		cpu_write(16'h8000, 8'h00);
		ciram_sweep(2'b10);
		cpu_write(16'h8000, 8'h10);
		ciram_sweep(2'b11);
		cpu_write(16'h5006, 8'h14); // MMC3
		cpu_write(16'hA000, 8'h00);
		ciram_sweep(2'b00);
		cpu_write(16'hA000, 8'h01);
		ciram_sweep(2'b01);
	endtask

	task automatic mmc3_banking();
		logic [7:0] r [8];
		for (int i = 0; i < 8; i++)
		begin
			rnd = $urandom;
			r[i] = rnd[7:0];
			cpu_write(16'h8000, {5'b00000, 3'(i)});
			cpu_write(16'h8001, r[i]);
		end
		chr_bank[0] = {r[0][7:1], 1'b0}; // R0 and R1 are 2 KB pairs
		chr_bank[1] = {r[0][7:1], 1'b1};
		chr_bank[2] = {r[1][7:1], 1'b0};
		chr_bank[3] = {r[1][7:1], 1'b1};
		for (int i = 2; i < 6; i++)
			chr_bank[i + 2] = r[i];
		prg_bank[0] = r[6][5:0];
		prg_bank[1] = r[7][5:0];
		prg_bank[2] = 6'd62;
		prg_bank[3] = 6'd63;
		prg_window_sweep(1'b0);
		chr_window_sweep(1'b0);
		cpu_write(16'h8000, 8'hC0); // Swap PRG and CHR halves
		prg_window_sweep(1'b1);
		chr_window_sweep(1'b1);
		cpu_write(16'h5007, 8'h80); // Lockout
		cpu_write(16'h5001, 8'hFF);
		cpu_write(16'h5006, 8'h01);
		prg_window_sweep(1'b1);
		cpu_write(16'h8000, 8'h06);
		prg_window_sweep(1'b0);
	endtask

	task automatic scanline_counting();
		ppu_access(14'h0000, 1'b1, 1'b1);
		cpu_write(16'hC000, 8'd4); // Latch N
		cpu_write(16'hC001, 8'h00);
		cpu_write(16'hE001, 8'h00);
		for (int i = 0; i < 4; i++)
		begin
			a12_pulse(3, 2);
			a12_pulse(1, 1); // Too short to count
			repeat (3) step();
			check("irq", 32'(irq), 1);
		end
		a12_pulse(3, 2);
		wait_irq(1'b0, "fall after the last counted scanline");
		repeat (4) step();
		check("irq", 32'(irq), 0);
		cpu_write(16'hE000, 8'h00);
		wait_irq(1'b1, "rise after the $E000 write");
	endtask

	initial
	begin
		rnd = $urandom(29);
		m2 = 1'b0;
		ppu_addr_in = 1'b1;
		romsel = 1'b1;
		cpu_rw_in = 1'b1;
		cpu_addr_in = '0;
		cpu_data_in = '0;
		ppu_rd_in = 1'b1;
		ppu_wr_in = 1'b1;
		ppu_a = '0;
		flash_we_seen = 1'b1;
		sram_we_seen = 1'b1;
		repeat (10) @(posedge m2);
		#2;
		ppu_addr_in = 1'b0;
		reset_defaults();
		config_and_sram();
		uxrom_banking();
		cnrom_chr();
		mirroring_modes();
		mmc3_banking();
		scanline_counting();
		$display("ALL TESTS PASSED");
		$finish;
	end
endmodule

// File: hdl/cool_mapper.sv
`timescale 1ns/10ps

module cool_mapper #(
	parameter bit use_mmc3 = 1'b1,
	parameter int a12_low_cycles = 3
) (
	input logic m2,
	input logic ppu_addr_in,
	input logic romsel,
	input logic cpu_rw_in,
	input mapper_pkg::cpu_addr_t cpu_addr_in,
	input mapper_pkg::byte_t cpu_data_in,
	input logic ppu_rd_in,
	input logic ppu_wr_in,
	input mapper_pkg::ppu_addr_t ppu_a,
	output logic [26:13] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe,
	output mapper_pkg::chr_bank_t ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10,
	output logic irq
);
	import mapper_pkg::*;

	irq_count_t irq_latch;
	logic irq_reload;
	logic irq_enable;

	bank_if u_banks ();

	cart_control #(
		.use_mmc3(use_mmc3)
	) u_cart_control (
		.m2(m2),
		.ppu_addr_in(ppu_addr_in),
		.romsel(romsel),
		.cpu_rw_in(cpu_rw_in),
		.cpu_addr_in(cpu_addr_in),
		.cpu_data_in(cpu_data_in),
		.banks(u_banks.ctrl),
		.irq_latch(irq_latch),
		.irq_reload(irq_reload),
		.irq_enable(irq_enable)
	);

	prg_map u_prg_map (
		.m2(m2),
		.romsel(romsel),
		.cpu_rw_in(cpu_rw_in),
		.cpu_addr_in(cpu_addr_in),
		.banks(u_banks.prg),
		.cpu_addr_out(cpu_addr_out),
		.flash_we(flash_we),
		.flash_oe(flash_oe),
		.sram_ce(sram_ce),
		.sram_we(sram_we),
		.sram_oe(sram_oe)
	);

	chr_map u_chr_map (
		.ppu_rd_in(ppu_rd_in),
		.ppu_wr_in(ppu_wr_in),
		.ppu_a(ppu_a),
		.banks(u_banks.chr),
		.ppu_addr_out(ppu_addr_out),
		.ppu_rd_out(ppu_rd_out),
		.ppu_wr_out(ppu_wr_out),
		.ppu_ciram_a10(ppu_ciram_a10)
	);

	scanline_irq #(
		.a12_low_cycles(a12_low_cycles)
	) u_scanline_irq (
		.m2(m2),
		.ppu_addr_in(ppu_addr_in),
		.ppu_a12(ppu_a[12]),
		.irq_latch(irq_latch),
		.irq_reload(irq_reload),
		.irq_enable(irq_enable),
		.irq(irq)
	);
endmodule

// File: hdl/scanline_irq.sv
`timescale 1ns/10ps

module scanline_irq #(
	parameter int a12_low_cycles = 3
) (
	input logic m2,
	input logic ppu_addr_in,
	input logic ppu_a12,
	input mapper_pkg::irq_count_t irq_latch,
	input logic irq_reload,
	input logic irq_enable,
	output logic irq
);
	import mapper_pkg::*;

	localparam int low_w = $clog2(a12_low_cycles + 1);

	logic [low_w-1:0] low_time; // Saturating count of low samples
	logic a12_q;
	logic a12_edge;
	logic reload_pending;
	irq_count_t counter;
	irq_count_t counter_next;
	logic fire;
	logic irq_active;

	assign a12_edge = ppu_a12 && !a12_q && low_time == low_w'(a12_low_cycles);
	assign counter_next = (reload_pending || counter == '0) ? irq_latch : counter - 8'd1;
	assign irq = ~irq_active;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			low_time <= '0;
			a12_q <= 1'b0;
			reload_pending <= 1'b0;
			counter <= '0;
			fire <= 1'b0;
			irq_active <= 1'b0;
		end
		else
		begin
			a12_q <= ppu_a12;
			if (ppu_a12)
				low_time <= '0;
			else if (low_time != low_w'(a12_low_cycles))
				low_time <= low_time + 1'b1;
			if (a12_edge)
				counter <= counter_next;
			if (irq_reload)
				reload_pending <= 1'b1;
			else if (a12_edge)
				reload_pending <= 1'b0;
			fire <= a12_edge && counter_next == '0 && irq_enable;
			irq_active <= irq_enable && (irq_active || fire); // Held until disabled
		end
	end

	// Clearing the enable from cart_control releases irq by the next edge
	assert property (@(posedge m2) disable iff (ppu_addr_in) !irq_enable |=> irq)
		else $error("irq still low after irq_enable cleared");
endmodule

// File: hdl/chr_map.sv
`timescale 1ns/10ps

module chr_map (
	input logic ppu_rd_in,
	input logic ppu_wr_in,
	input mapper_pkg::ppu_addr_t ppu_a,
	bank_if.chr banks,
	output mapper_pkg::chr_bank_t ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10
);
	import mapper_pkg::*;

	chr_bank_t mapped;

	always_comb
	begin
		case (banks.chr_mode)
			chr_mode_2k_lo, chr_mode_2k_hi:
			begin
				if (ppu_a[12] ^ banks.chr_mode[0]) // 1 KB half
				begin
					case (ppu_a[11:10])
						2'b00: mapped = banks.chr_bank_e;
						2'b01: mapped = banks.chr_bank_f;
						2'b10: mapped = banks.chr_bank_g;
						default: mapped = banks.chr_bank_h;
					endcase
				end
				else
				begin
					case (ppu_a[11:10]) // 2 KB pairs A/B and C/D
						2'b00: mapped = banks.chr_bank_a;
						2'b01: mapped = banks.chr_bank_b;
						2'b10: mapped = banks.chr_bank_c;
						default: mapped = banks.chr_bank_d;
					endcase
				end
			end
			default: mapped = {banks.chr_bank_a[7:3], ppu_a[12:10]}; // Plain 8 KB
		endcase
	end

	assign ppu_addr_out = {mapped[7:3] & ~banks.chr_mask, mapped[2:0]};
	assign ppu_rd_out = ppu_rd_in | ppu_a[13];
	assign ppu_wr_out = ppu_wr_in | ppu_a[13] | ~banks.chr_write_enabled;

	always_comb
	begin
		case (banks.mirroring)
			mirror_vertical: ppu_ciram_a10 = ppu_a[10];
			mirror_horizontal: ppu_ciram_a10 = ppu_a[11];
			mirror_single_a: ppu_ciram_a10 = 1'b0;
			default: ppu_ciram_a10 = 1'b1;
		endcase
	end
endmodule

// File: hdl/prg_map.sv
`timescale 1ns/10ps

module prg_map (
	input logic m2,
	input logic romsel,
	input logic cpu_rw_in,
	input mapper_pkg::cpu_addr_t cpu_addr_in,
	bank_if.prg banks,
	output logic [26:13] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe
);
	import mapper_pkg::*;

	prg_bank_t mapped;        // A18-A13 before base and mask
	logic [26:13] rom_addr;
	logic sram_sel;

	always_comb
	begin
		casez (banks.prg_mode)
			prg_mode_8k, prg_mode_8k_swap:
			begin
				case (cpu_addr_in[14:13])
					2'b00: mapped = banks.prg_mode[0] ? banks.prg_bank_c : banks.prg_bank_a;
					2'b01: mapped = banks.prg_bank_b;
					2'b10: mapped = banks.prg_mode[0] ? banks.prg_bank_a : banks.prg_bank_c;
					default: mapped = banks.prg_bank_d;
				endcase
			end
			3'b11?: mapped = {banks.prg_bank_a[5:2], cpu_addr_in[14:13]}; // 32 KB
			default: mapped = {cpu_addr_in[14] ? 5'b11111 : banks.prg_bank_a[5:1], cpu_addr_in[13]};
		endcase
	end

	assign rom_addr = {banks.cpu_base | {8'd0, mapped[5:1] & ~banks.prg_mask}, mapped[0]};

	// $6000-$7FFF while m2 is high
	assign sram_sel = cpu_addr_in[14] && cpu_addr_in[13] && romsel && m2 && banks.sram_enabled;

	assign cpu_addr_out = sram_sel ? {rom_addr[26:15], banks.sram_page} : rom_addr;
	assign flash_we = cpu_rw_in | romsel | ~banks.prg_write_enabled;
	assign flash_oe = ~(cpu_rw_in & m2 & ~romsel);
	assign sram_ce = ~sram_sel;
	assign sram_we = cpu_rw_in | ~sram_sel;
	assign sram_oe = ~cpu_rw_in | ~sram_sel;

	// Flash and SRAM never share the data bus
	assert property (@(negedge m2) flash_oe || sram_ce)
		else $error("flash_oe and sram_ce both active");
endmodule

// File: hdl/cart_control.sv
`timescale 1ns/10ps

module cart_control #(
	parameter bit use_mmc3 = 1'b1
) (
	input logic m2,
	input logic ppu_addr_in,
	input logic romsel,
	input logic cpu_rw_in,
	input mapper_pkg::cpu_addr_t cpu_addr_in,
	input mapper_pkg::byte_t cpu_data_in,
	bank_if.ctrl banks,
	output mapper_pkg::irq_count_t irq_latch,
	output logic irq_reload,
	output logic irq_enable
);
	import mapper_pkg::*;

	bus_state_t bus_state;
	mapper_t mapper;
	logic lockout;
	logic [2:0] bank_sel; // MMC3 bank select
	logic cpu_write;

	// Second write of a read-modify-write is dropped
	assign cpu_write = !cpu_rw_in && bus_state == bus_idle;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			bus_state <= bus_idle;
			mapper <= '0;
			lockout <= 1'b0;
			bank_sel <= '0;
			irq_latch <= '0;
			irq_reload <= 1'b0;
			irq_enable <= 1'b0;
			banks.cpu_base <= '0;
			banks.prg_mask <= '0;
			banks.prg_mode <= '0;
			banks.prg_bank_a <= 6'd0;
			banks.prg_bank_b <= 6'd61;
			banks.prg_bank_c <= 6'd62;
			banks.prg_bank_d <= 6'd63;
			banks.chr_mode <= '0;
			banks.chr_mask <= '0;
			banks.chr_bank_a <= 8'd0;
			banks.chr_bank_b <= 8'd1;
			banks.chr_bank_c <= 8'd2;
			banks.chr_bank_d <= 8'd3;
			banks.chr_bank_e <= 8'd4;
			banks.chr_bank_f <= 8'd5;
			banks.chr_bank_g <= 8'd6;
			banks.chr_bank_h <= 8'd7;
			banks.mirroring <= mirror_vertical;
			banks.sram_enabled <= 1'b0;
			banks.sram_page <= '0;
			banks.prg_write_enabled <= 1'b0;
			banks.chr_write_enabled <= 1'b0;
		end
		else
		begin
			irq_reload <= 1'b0;
			if (cpu_rw_in)
				bus_state <= bus_idle;
			else
				bus_state <= bus_wrote;
			if (cpu_write && romsel)
			begin
				if (cpu_addr_in[14:12] == 3'b101 && !lockout) // $5000-$5FFF
				begin
					case (cpu_addr_in[2:0])
						3'd0: {banks.prg_mode, banks.cpu_base[26:22]} <= cpu_data_in;
						3'd1: banks.cpu_base[21:14] <= cpu_data_in;
						3'd2: banks.prg_mask <= cpu_data_in[4:0];
						3'd3: {banks.chr_mode, banks.chr_bank_a[7:3]} <= cpu_data_in;
						3'd4: banks.chr_mask <= cpu_data_in[4:0];
						3'd5: {banks.prg_bank_a[5:1], banks.sram_page} <= cpu_data_in[6:0];
						3'd6: mapper <= cpu_data_in[4:0]; // Flag bits 7-5 unused
						default: {lockout, banks.mirroring, banks.prg_write_enabled,
							banks.chr_write_enabled, banks.sram_enabled} <=
							{cpu_data_in[7], cpu_data_in[4:0]};
					endcase
				end
			end
			else if (cpu_write)
			begin
				case (mapper)
					mapper_uxrom: banks.prg_bank_a[5:1] <= cpu_data_in[4:0];
					mapper_cnrom: banks.chr_bank_a[7:3] <= cpu_data_in[4:0];
					mapper_axrom:
					begin
						banks.prg_bank_a[5:2] <= cpu_data_in[3:0];
						banks.mirroring <= cpu_data_in[4] ? mirror_single_b : mirror_single_a;
					end
					mapper_mmc3:
					begin
						if (use_mmc3)
						begin
							case ({cpu_addr_in[14:13], cpu_addr_in[0]})
								3'b000:
								begin
									bank_sel <= cpu_data_in[2:0];
									banks.prg_mode <= cpu_data_in[6] ? prg_mode_8k_swap : prg_mode_8k;
									banks.chr_mode <= cpu_data_in[7] ? chr_mode_2k_hi : chr_mode_2k_lo;
								end
								3'b001:
								begin
									case (bank_sel)
										3'd0:
										begin
											banks.chr_bank_a <= {cpu_data_in[7:1], 1'b0}; // 2 KB pair
											banks.chr_bank_b <= {cpu_data_in[7:1], 1'b1};
										end
										3'd1:
										begin
											banks.chr_bank_c <= {cpu_data_in[7:1], 1'b0};
											banks.chr_bank_d <= {cpu_data_in[7:1], 1'b1};
										end
										3'd2: banks.chr_bank_e <= cpu_data_in;
										3'd3: banks.chr_bank_f <= cpu_data_in;
										3'd4: banks.chr_bank_g <= cpu_data_in;
										3'd5: banks.chr_bank_h <= cpu_data_in;
										3'd6: banks.prg_bank_a <= cpu_data_in[5:0];
										default: banks.prg_bank_b <= cpu_data_in[5:0];
									endcase
								end
								3'b010: banks.mirroring <= cpu_data_in[0] ? mirror_horizontal : mirror_vertical;
								3'b100: irq_latch <= cpu_data_in;
								3'b101: irq_reload <= 1'b1;
								3'b110: irq_enable <= 1'b0; // Also acks
								3'b111: irq_enable <= 1'b1;
								default: ; // WRAM protect ignored
							endcase
						end
					end
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge m2) disable iff (ppu_addr_in)
		!$isunknown(bus_state) && bus_state inside {bus_idle, bus_wrote})
		else $error("write filter in illegal state");
endmodule

// File: hdl/bank_if.sv
`timescale 1ns/10ps

interface bank_if;
	import mapper_pkg::*;

	cpu_base_t cpu_base;
	prg_mask_t prg_mask;
	mode_t prg_mode;
	prg_bank_t prg_bank_a, prg_bank_b, prg_bank_c, prg_bank_d;
	mode_t chr_mode;
	chr_mask_t chr_mask;
	chr_bank_t chr_bank_a, chr_bank_b, chr_bank_c, chr_bank_d;
	chr_bank_t chr_bank_e, chr_bank_f, chr_bank_g, chr_bank_h;
	mirror_t mirroring;
	logic sram_enabled;
	sram_page_t sram_page;
	logic prg_write_enabled;
	logic chr_write_enabled;

	modport ctrl (
		output cpu_base, prg_mask, prg_mode, prg_bank_a, prg_bank_b, prg_bank_c, prg_bank_d,
		output chr_mode, chr_mask, chr_bank_a, chr_bank_b, chr_bank_c, chr_bank_d,
		output chr_bank_e, chr_bank_f, chr_bank_g, chr_bank_h,
		output mirroring, sram_enabled, sram_page, prg_write_enabled, chr_write_enabled
	);

	modport prg (
		input cpu_base, prg_mask, prg_mode, prg_bank_a, prg_bank_b, prg_bank_c, prg_bank_d,
		input sram_enabled, sram_page, prg_write_enabled
	);

	modport chr (
		input chr_mode, chr_mask, chr_bank_a, chr_bank_b, chr_bank_c, chr_bank_d,
		input chr_bank_e, chr_bank_f, chr_bank_g, chr_bank_h, mirroring, chr_write_enabled
	);
endinterface

// File: hdl/mapper_pkg.sv
package mapper_pkg;
	typedef logic [7:0] byte_t;          // CPU data bus
	typedef logic [14:0] cpu_addr_t;     // CPU A14-A0
	typedef logic [13:0] ppu_addr_t;     // PPU A13-A0
	typedef logic [5:0] prg_bank_t;      // 8 KB bank, A18-A13
	typedef logic [7:0] chr_bank_t;      // 1 KB bank, A17-A10
	typedef logic [26:14] cpu_base_t;
	typedef logic [18:14] prg_mask_t;
	typedef logic [17:13] chr_mask_t;
	typedef logic [2:0] mode_t;
	typedef logic [4:0] mapper_t;
	typedef logic [1:0] mirror_t;
	typedef logic [1:0] sram_page_t;
	typedef logic [7:0] irq_count_t;

	// Write filter, one register write per bus access
	typedef enum logic {
		bus_idle,
		bus_wrote
	} bus_state_t;

	localparam mapper_t mapper_uxrom = 5'b00001;
	localparam mapper_t mapper_cnrom = 5'b00010;
	localparam mapper_t mapper_axrom = 5'b01000;
	localparam mapper_t mapper_mmc3 = 5'b10100;

	localparam mode_t prg_mode_8k = 3'b100;      // A, B, C, D
	localparam mode_t prg_mode_8k_swap = 3'b101; // C, B, A, D
	localparam mode_t chr_mode_2k_lo = 3'b010;   // 2 KB pairs at $0000
	localparam mode_t chr_mode_2k_hi = 3'b011;   // 2 KB pairs at $1000

	localparam mirror_t mirror_vertical = 2'b00;
	localparam mirror_t mirror_horizontal = 2'b01;
	localparam mirror_t mirror_single_a = 2'b10;
	localparam mirror_t mirror_single_b = 2'b11;
endpackage
